// File: hw/ctrl_settings.svh
// controller field widths, included by the packages that build their enums on them
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// controller encodings
////////////////////////////////////////////////////////////////////////////

// fsm state code, seven states used
`define CTRL_STATE_W 3

// fetch stage pc mux select
`define CTRL_PC_SEL_W 3

////////////////////////////////////////////////////////////////////////////
// pipeline encodings
////////////////////////////////////////////////////////////////////////////

// jump kind seen by the decoder
`define CTRL_JUMP_W 2

// operand forwarding mux select
`define CTRL_FWD_SEL_W 2

`endif

// File: hw/ctrl_pkg.sv
// controller types shared by the FSM, the top level and the testbench checks
`include "ctrl_settings.svh"

package ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // main controller states
  ////////////////////////////////////////////////////////////////////////////

  // reset, boot and sleep come first, then normal decode and the flush steps
  typedef enum logic [`CTRL_STATE_W-1:0] {
    RESET       = 3'd0,
    BOOT_SET    = 3'd1,
    SLEEP       = 3'd2,
    FIRST_FETCH = 3'd3,
    DECODE      = 3'd4,
    FLUSH_EX    = 3'd5,
    FLUSH_WB    = 3'd6
  } ctrl_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // pc mux select towards the fetch stage
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [`CTRL_PC_SEL_W-1:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_BRANCH    = 3'd2,
    PC_EXCEPTION = 3'd3,
    PC_ERET      = 3'd4
  } pc_sel_e;

endpackage

// File: hw/pipe_pkg.sv
// pipeline encodings for jump kinds and operand forwarding, used by control and checks
`include "ctrl_settings.svh"

package pipe_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // jump kind from the decoder
  ////////////////////////////////////////////////////////////////////////////

  // cond is resolved in EX, jal and jalr are taken straight from ID
  typedef enum logic [`CTRL_JUMP_W-1:0] {
    JUMP_NONE = 2'b00,
    JUMP_JAL  = 2'b01,
    JUMP_JALR = 2'b10,
    JUMP_COND = 2'b11
  } jump_kind_e;

  // operand source for the ID stage register read
  typedef enum logic [`CTRL_FWD_SEL_W-1:0] {
    FWD_REGFILE = 2'b00,
    FWD_EX      = 2'b01,
    FWD_WB      = 2'b10
  } fwd_sel_e;

endpackage

// File: hw/ctrl_fsm.sv
// main controller FSM, steers the fetch pc, raises halts and sequences boot, flush and sleep
`timescale 1ns/1ps

module ctrl_fsm
(
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  fetch_enable_i,
  input  logic                  instr_valid_i,
  input  logic                  eret_insn_i,
  input  logic                  pipe_flush_i,
  input  pipe_pkg::jump_kind_e  jump_in_dec_i,
  input  logic                  branch_taken_ex_i,
  input  logic                  exc_req_i,
  input  logic                  id_valid_i,
  input  logic                  ex_valid_i,
  input  logic                  wb_valid_i,
  input  logic                  jr_stall_i,

  output logic                  core_busy_o,
  output logic                  is_decoding_o,
  output logic                  instr_req_o,
  output logic                  pc_set_o,
  output ctrl_pkg::pc_sel_e     pc_mux_o,
  output logic                  exc_ack_o,
  output logic                  save_pc_id_o,
  output logic                  halt_if_o,
  output logic                  halt_id_o
);

  ctrl_pkg::ctrl_state_e state_q;
  ctrl_pkg::ctrl_state_e state_d;

  // one pc_set per jump, held until ID moves on
  logic jump_done_q;
  logic jump_done_d;

  logic is_jump;

  // jal and jalr redirect from ID, cond waits for EX
  assign is_jump = (jump_in_dec_i == pipe_pkg::JUMP_JAL) ||
                   (jump_in_dec_i == pipe_pkg::JUMP_JALR);

  ////////////////////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    // defaults for a running core
    state_d       = state_q;
    jump_done_d   = jump_done_q;
    core_busy_o   = 1'b1;
    instr_req_o   = 1'b1;
    is_decoding_o = 1'b0;
    pc_set_o      = 1'b0;
    pc_mux_o      = ctrl_pkg::PC_BOOT;
    exc_ack_o     = 1'b0;
    save_pc_id_o  = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;

    case (state_q)
      ctrl_pkg::RESET:
      begin
        // idle until fetching is allowed
        core_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          state_d = ctrl_pkg::BOOT_SET;
      end

      ctrl_pkg::BOOT_SET:
      begin
        // load the boot address into the fetch pc, single cycle
        pc_mux_o = ctrl_pkg::PC_BOOT;
        pc_set_o = 1'b1;
        state_d  = ctrl_pkg::FIRST_FETCH;
      end

      ctrl_pkg::SLEEP:
      begin
        core_busy_o = 1'b0;
        instr_req_o = 1'b0;
        // wake on enable or on a pending exception
        if (fetch_enable_i || exc_req_i)
          state_d = ctrl_pkg::FIRST_FETCH;
      end

      ctrl_pkg::FIRST_FETCH:
      begin
        // wait for the first instruction to reach ID
        if (id_valid_i)
          state_d = ctrl_pkg::DECODE;

        // an exception here jumps before anything is decoded
        if (exc_req_i)
        begin
          pc_mux_o     = ctrl_pkg::PC_EXCEPTION;
          pc_set_o     = 1'b1;
          exc_ack_o    = 1'b1;
          save_pc_id_o = 1'b1;
        end
      end

      ctrl_pkg::DECODE:
      begin
        if (instr_valid_i && !branch_taken_ex_i)
        begin
          is_decoding_o = 1'b1;

          if (is_jump)
          begin
            pc_mux_o = ctrl_pkg::PC_JUMP;
            // jalr waits for its base register, and a jump is issued only once
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end
          else if (exc_req_i)
          begin
            pc_mux_o     = ctrl_pkg::PC_EXCEPTION;
            pc_set_o     = 1'b1;
            exc_ack_o    = 1'b1;
            // keep the faulting instruction out of EX
            halt_id_o    = 1'b1;
            save_pc_id_o = 1'b1;
          end

          // eret overrides the pc choice above
          if (eret_insn_i)
          begin
            pc_mux_o = ctrl_pkg::PC_ERET;
            pc_set_o = 1'b1;
          end

          // wfi, or an eret back into sleep, drains the pipeline first
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i))
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = ctrl_pkg::FLUSH_EX;
          end
        end

        // taken branch in EX wins over everything in ID
        if (branch_taken_ex_i)
        begin
          pc_mux_o      = ctrl_pkg::PC_BRANCH;
          pc_set_o      = 1'b1;
          is_decoding_o = 1'b0;
        end
      end

      ctrl_pkg::FLUSH_EX:
      begin
        // bubble into EX until the last instruction leaves it
        halt_if_o = 1'b1;
        if (ex_valid_i)
          state_d = ctrl_pkg::FLUSH_WB;
      end

      ctrl_pkg::FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        if (!fetch_enable_i)
        begin
          // drain WB, then sleep
          if (wb_valid_i)
            state_d = ctrl_pkg::SLEEP;
        end
        else
        begin
          // still enabled, resume fetching
          halt_if_o = 1'b0;
          if (id_valid_i)
            state_d = ctrl_pkg::DECODE;
        end
      end

      default:
      begin
        // unused code, recover through reset
        core_busy_o = 1'b0;
        instr_req_o = 1'b0;
        state_d     = ctrl_pkg::RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= ctrl_pkg::RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // cleared once ID accepts the next instruction
      jump_done_q <= jump_done_d & ~id_valid_i;
    end
  end

endmodule

// File: hw/hazard_unit.sv
// hazard detection for load-use and jump-register stalls, plus write-enable suppression
`timescale 1ns/1ps

module hazard_unit
(
  input  logic                  is_decoding_i,
  input  logic                  illegal_insn_i,
  input  logic                  data_req_ex_i,
  input  pipe_pkg::jump_kind_e  jump_in_dec_i,

  input  logic                  regfile_we_ex_i,
  input  logic                  regfile_we_wb_i,
  input  logic                  regfile_alu_we_fw_i,

  input  logic                  ex_is_a_i,
  input  logic                  ex_is_b_i,
  input  logic                  ex_is_c_i,
  input  logic                  wb_is_a_i,
  input  logic                  alu_is_a_i,

  output logic                  load_stall_o,
  output logic                  jr_stall_o,
  output logic                  deassert_we_o
);

  logic ex_hit_any;
  logic a_pending;

  // destination in EX matches one of the ID operands
  assign ex_hit_any = ex_is_a_i | ex_is_b_i | ex_is_c_i;

  // operand a still being produced somewhere down the pipe
  assign a_pending = (regfile_we_wb_i     & wb_is_a_i) |
                     (regfile_we_ex_i     & ex_is_a_i) |
                     (regfile_alu_we_fw_i & alu_is_a_i);

  ////////////////////////////////////////////////////////////////////////////
  // stall decisions
  ////////////////////////////////////////////////////////////////////////////

  // load data arrives too late for forwarding
  assign load_stall_o = data_req_ex_i & regfile_we_ex_i & ex_hit_any;

  // jalr target is taken in ID, so its base must be settled
  assign jr_stall_o = (jump_in_dec_i == pipe_pkg::JUMP_JALR) & a_pending;

  // no register write from an instruction that is not really issued
  assign deassert_we_o = ~is_decoding_i | illegal_insn_i |
                         load_stall_o | jr_stall_o;

endmodule

// File: hw/fwd_unit.sv
// operand forwarding mux selects for the three ID stage register operands
`timescale 1ns/1ps

module fwd_unit
(
  input  logic                regfile_we_wb_i,
  input  logic                regfile_alu_we_fw_i,

  input  logic                wb_is_a_i,
  input  logic                wb_is_b_i,
  input  logic                wb_is_c_i,
  input  logic                alu_is_a_i,
  input  logic                alu_is_b_i,
  input  logic                alu_is_c_i,

  output pipe_pkg::fwd_sel_e  operand_a_fw_o,
  output pipe_pkg::fwd_sel_e  operand_b_fw_o,
  output pipe_pkg::fwd_sel_e  operand_c_fw_o
);

  // newest value wins, so the ALU result is checked before WB
  function automatic pipe_pkg::fwd_sel_e pick_src(input logic alu_hit, input logic wb_hit);
    pipe_pkg::fwd_sel_e sel;
    if (alu_hit)
      sel = pipe_pkg::FWD_EX;
    else if (wb_hit)
      sel = pipe_pkg::FWD_WB;
    else
      sel = pipe_pkg::FWD_REGFILE;
    return sel;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // per operand select
  ////////////////////////////////////////////////////////////////////////////

  assign operand_a_fw_o = pick_src(regfile_alu_we_fw_i & alu_is_a_i,
                                   regfile_we_wb_i & wb_is_a_i);

  assign operand_b_fw_o = pick_src(regfile_alu_we_fw_i & alu_is_b_i,
                                   regfile_we_wb_i & wb_is_b_i);

  assign operand_c_fw_o = pick_src(regfile_alu_we_fw_i & alu_is_c_i,
                                   regfile_we_wb_i & wb_is_c_i);

endmodule

// File: hw/ctrl_top.sv
// controller top level joining the FSM, the hazard unit and the forwarding unit
`timescale 1ns/1ps

module ctrl_top
(
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  fetch_enable_i,
  input  logic                  instr_valid_i,
  input  logic                  illegal_insn_i,
  input  logic                  eret_insn_i,
  input  logic                  pipe_flush_i,
  input  pipe_pkg::jump_kind_e  jump_in_dec_i,
  input  logic                  branch_taken_ex_i,
  input  logic                  exc_req_i,
  input  logic                  data_req_ex_i,

  input  logic                  id_valid_i,
  input  logic                  ex_valid_i,
  input  logic                  wb_valid_i,

  input  logic                  regfile_we_ex_i,
  input  logic                  regfile_we_wb_i,
  input  logic                  regfile_alu_we_fw_i,

  input  logic                  ex_is_a_i,
  input  logic                  ex_is_b_i,
  input  logic                  ex_is_c_i,
  input  logic                  wb_is_a_i,
  input  logic                  wb_is_b_i,
  input  logic                  wb_is_c_i,
  input  logic                  alu_is_a_i,
  input  logic                  alu_is_b_i,
  input  logic                  alu_is_c_i,

  output logic                  core_busy_o,
  output logic                  is_decoding_o,
  output logic                  instr_req_o,
  output logic                  pc_set_o,
  output ctrl_pkg::pc_sel_e     pc_mux_o,
  output logic                  exc_ack_o,
  output logic                  save_pc_id_o,
  output logic                  halt_if_o,
  output logic                  halt_id_o,
  output logic                  deassert_we_o,
  output logic                  load_stall_o,
  output logic                  jr_stall_o,
  output pipe_pkg::fwd_sel_e    operand_a_fw_o,
  output pipe_pkg::fwd_sel_e    operand_b_fw_o,
  output pipe_pkg::fwd_sel_e    operand_c_fw_o
);

  // fsm and hazard unit feed each other, without a loop
  logic jr_stall;
  logic is_decoding;

  assign jr_stall_o    = jr_stall;
  assign is_decoding_o = is_decoding;

  ////////////////////////////////////////////////////////////////////////////
  // main FSM
  ////////////////////////////////////////////////////////////////////////////

  ctrl_fsm fsm_i
  (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .eret_insn_i       (eret_insn_i),
    .pipe_flush_i      (pipe_flush_i),
    .jump_in_dec_i     (jump_in_dec_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .exc_req_i         (exc_req_i),
    .id_valid_i        (id_valid_i),
    .ex_valid_i        (ex_valid_i),
    .wb_valid_i        (wb_valid_i),
    .jr_stall_i        (jr_stall),
    .core_busy_o       (core_busy_o),
    .is_decoding_o     (is_decoding),
    .instr_req_o       (instr_req_o),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .exc_ack_o         (exc_ack_o),
    .save_pc_id_o      (save_pc_id_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // stalls and forwarding
  ////////////////////////////////////////////////////////////////////////////

  hazard_unit hazard_i
  (
    .is_decoding_i       (is_decoding),
    .illegal_insn_i      (illegal_insn_i),
    .data_req_ex_i       (data_req_ex_i),
    .jump_in_dec_i       (jump_in_dec_i),
    .regfile_we_ex_i     (regfile_we_ex_i),
    .regfile_we_wb_i     (regfile_we_wb_i),
    .regfile_alu_we_fw_i (regfile_alu_we_fw_i),
    .ex_is_a_i           (ex_is_a_i),
    .ex_is_b_i           (ex_is_b_i),
    .ex_is_c_i           (ex_is_c_i),
    .wb_is_a_i           (wb_is_a_i),
    .alu_is_a_i          (alu_is_a_i),
    .load_stall_o        (load_stall_o),
    .jr_stall_o          (jr_stall),
    .deassert_we_o       (deassert_we_o)
  );

  // operand selects depend only on the match flags and write enables
  fwd_unit fwd_i
  (
    .regfile_we_wb_i     (regfile_we_wb_i),
    .regfile_alu_we_fw_i (regfile_alu_we_fw_i),
    .wb_is_a_i           (wb_is_a_i),
    .wb_is_b_i           (wb_is_b_i),
    .wb_is_c_i           (wb_is_c_i),
    .alu_is_a_i          (alu_is_a_i),
    .alu_is_b_i          (alu_is_b_i),
    .alu_is_c_i          (alu_is_c_i),
    .operand_a_fw_o      (operand_a_fw_o),
    .operand_b_fw_o      (operand_b_fw_o),
    .operand_c_fw_o      (operand_c_fw_o)
  );

endmodule

// File: verif/tb_ctrl_ref.svh
// reference models, random source and typed compare tasks, included inside the controller testbench
`ifndef TB_CTRL_REF_SVH
`define TB_CTRL_REF_SVH

////////////////////////////////////////////////////////////////////////////
// random source
////////////////////////////////////////////////////////////////////////////

// galois form, right shift, taps for x^32 + x^30 + x^26 + x^25 + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  logic [31:0] nxt;
  nxt = s >> 1;
  if (s[0])
    nxt = nxt ^ 32'hA300_0000;
  return nxt;
endfunction

// one lfsr step per bit, newest bit lands in the lsb
task automatic draw_bits(input int unsigned n, output logic [31:0] bits);
  bits = '0;
  for (int unsigned i = 0; i < n; i++)
  begin
    lfsr_state = lfsr_step(lfsr_state);
    bits       = {bits[30:0], lfsr_state[0]};
  end
endtask

////////////////////////////////////////////////////////////////////////////
// expected values
////////////////////////////////////////////////////////////////////////////

// alu path is the younger producer, so it beats WB
function automatic pipe_pkg::fwd_sel_e ref_fwd(input logic we_alu, input logic we_wb,
                                               input logic alu_hit, input logic wb_hit);
  pipe_pkg::fwd_sel_e exp;
  case ({we_alu & alu_hit, we_wb & wb_hit})
    2'b10, 2'b11: exp = pipe_pkg::FWD_EX;
    2'b01:        exp = pipe_pkg::FWD_WB;
    default:      exp = pipe_pkg::FWD_REGFILE;
  endcase
  return exp;
endfunction

// result packed as {load stall, jr stall, we suppress}
function automatic logic [2:0] ref_hazard(input logic decoding, input logic illegal,
                                          input logic load_in_ex,
                                          input pipe_pkg::jump_kind_e jump,
                                          input logic we_ex, input logic we_wb,
                                          input logic we_alu, input logic ex_a,
                                          input logic ex_b, input logic ex_c,
                                          input logic wb_a, input logic alu_a);
  logic load;
  logic jr;
  logic dwe;
  load = load_in_ex && we_ex && (ex_a || ex_b || ex_c);
  jr   = 1'b0;
  // only jalr reads a register in ID for its target
  if (jump == pipe_pkg::JUMP_JALR)
    jr = (we_wb && wb_a) || (we_ex && ex_a) || (we_alu && alu_a);
  dwe = !decoding || illegal || load || jr;
  return {load, jr, dwe};
endfunction

////////////////////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////////////////////

task automatic cmp_fwd(input string name, input pipe_pkg::fwd_sel_e exp,
                       input pipe_pkg::fwd_sel_e act);
  check_count++;
  if (act !== exp)
  begin
    err_count++;
    $display("CHECK FAILED %s: expected %s, actual %s", name, exp.name(), act.name());
  end
endtask

task automatic cmp_pc(input string name, input ctrl_pkg::pc_sel_e exp,
                      input ctrl_pkg::pc_sel_e act);
  check_count++;
  if (act !== exp)
  begin
    err_count++;
    $display("CHECK FAILED %s: expected %s, actual %s", name, exp.name(), act.name());
  end
endtask

task automatic cmp_bit(input string name, input logic exp, input logic act);
  check_count++;
  if (act !== exp)
  begin
    err_count++;
    $display("CHECK FAILED %s: expected %0b, actual %0b", name, exp, act);
  end
endtask

`endif

// File: verif/tb_ctrl.sv
// testbench for the controller top level, run from the file list with tb_ctrl as top
`timescale 1ns/1ps

module tb_ctrl;

  localparam int CLK_PERIOD_NS   = 4;
  localparam int RESET_CYCLES    = 3;
  localparam int RANDOM_CYCLES   = 200;
  // boot, directed decode cases, jalr and flush, rounded up
  localparam int DIRECTED_CYCLES = 80;
  localparam int TOTAL_CYCLES    = RESET_CYCLES + RANDOM_CYCLES + DIRECTED_CYCLES;
  localparam int TIMEOUT_NS      = TOTAL_CYCLES * CLK_PERIOD_NS + 400;

  logic clk = 1'b0;
  logic rst_n;

  // DUT inputs
  logic                 fetch_enable;
  logic                 instr_valid;
  logic                 illegal_insn;
  logic                 eret_insn;
  logic                 pipe_flush;
  pipe_pkg::jump_kind_e jump_in_dec;
  logic                 branch_taken_ex;
  logic                 exc_req;
  logic                 data_req_ex;
  logic                 id_valid;
  logic                 ex_valid;
  logic                 wb_valid;
  logic                 regfile_we_ex;
  logic                 regfile_we_wb;
  logic                 regfile_alu_we_fw;
  logic                 ex_is_a;
  logic                 ex_is_b;
  logic                 ex_is_c;
  logic                 wb_is_a;
  logic                 wb_is_b;
  logic                 wb_is_c;
  logic                 alu_is_a;
  logic                 alu_is_b;
  logic                 alu_is_c;

  // DUT outputs
  logic                 core_busy;
  logic                 is_decoding;
  logic                 instr_req;
  logic                 pc_set;
  ctrl_pkg::pc_sel_e    pc_mux;
  logic                 exc_ack;
  logic                 save_pc_id;
  logic                 halt_if;
  logic                 halt_id;
  logic                 deassert_we;
  logic                 load_stall;
  logic                 jr_stall;
  pipe_pkg::fwd_sel_e   operand_a_fw;
  pipe_pkg::fwd_sel_e   operand_b_fw;
  pipe_pkg::fwd_sel_e   operand_c_fw;

  int unsigned err_count   = 0;
  int unsigned check_count = 0;
  logic [31:0] lfsr_state  = 32'h15a0;

  `include "tb_ctrl_ref.svh"

  always #(CLK_PERIOD_NS / 2) clk = ~clk;

  ctrl_top dut_i
  (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_enable_i      (fetch_enable),
    .instr_valid_i       (instr_valid),
    .illegal_insn_i      (illegal_insn),
    .eret_insn_i         (eret_insn),
    .pipe_flush_i        (pipe_flush),
    .jump_in_dec_i       (jump_in_dec),
    .branch_taken_ex_i   (branch_taken_ex),
    .exc_req_i           (exc_req),
    .data_req_ex_i       (data_req_ex),
    .id_valid_i          (id_valid),
    .ex_valid_i          (ex_valid),
    .wb_valid_i          (wb_valid),
    .regfile_we_ex_i     (regfile_we_ex),
    .regfile_we_wb_i     (regfile_we_wb),
    .regfile_alu_we_fw_i (regfile_alu_we_fw),
    .ex_is_a_i           (ex_is_a),
    .ex_is_b_i           (ex_is_b),
    .ex_is_c_i           (ex_is_c),
    .wb_is_a_i           (wb_is_a),
    .wb_is_b_i           (wb_is_b),
    .wb_is_c_i           (wb_is_c),
    .alu_is_a_i          (alu_is_a),
    .alu_is_b_i          (alu_is_b),
    .alu_is_c_i          (alu_is_c),
    .core_busy_o         (core_busy),
    .is_decoding_o       (is_decoding),
    .instr_req_o         (instr_req),
    .pc_set_o            (pc_set),
    .pc_mux_o            (pc_mux),
    .exc_ack_o           (exc_ack),
    .save_pc_id_o        (save_pc_id),
    .halt_if_o           (halt_if),
    .halt_id_o           (halt_id),
    .deassert_we_o       (deassert_we),
    .load_stall_o        (load_stall),
    .jr_stall_o          (jr_stall),
    .operand_a_fw_o      (operand_a_fw),
    .operand_b_fw_o      (operand_b_fw),
    .operand_c_fw_o      (operand_c_fw)
  );

  // everything except fetch enable and instr valid back to idle
  task automatic clear_inputs();
    illegal_insn      <= 1'b0;
    eret_insn         <= 1'b0;
    pipe_flush        <= 1'b0;
    jump_in_dec       <= pipe_pkg::JUMP_NONE;
    branch_taken_ex   <= 1'b0;
    exc_req           <= 1'b0;
    data_req_ex       <= 1'b0;
    id_valid          <= 1'b0;
    ex_valid          <= 1'b0;
    wb_valid          <= 1'b0;
    regfile_we_ex     <= 1'b0;
    regfile_we_wb     <= 1'b0;
    regfile_alu_we_fw <= 1'b0;
    {ex_is_a, ex_is_b, ex_is_c}    <= 3'b000;
    {wb_is_a, wb_is_b, wb_is_c}    <= 3'b000;
    {alu_is_a, alu_is_b, alu_is_c} <= 3'b000;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // forwarding and hazard compare, every cycle out of reset
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin : compare_outputs
    logic [2:0] exp_haz;
    if (rst_n)
    begin
      cmp_fwd("fwd operand a", ref_fwd(regfile_alu_we_fw, regfile_we_wb, alu_is_a, wb_is_a),
              operand_a_fw);
      cmp_fwd("fwd operand b", ref_fwd(regfile_alu_we_fw, regfile_we_wb, alu_is_b, wb_is_b),
              operand_b_fw);
      cmp_fwd("fwd operand c", ref_fwd(regfile_alu_we_fw, regfile_we_wb, alu_is_c, wb_is_c),
              operand_c_fw);
      // decode status comes from the DUT, it is checked directly by the directed cases
      exp_haz = ref_hazard(is_decoding, illegal_insn, data_req_ex, jump_in_dec,
                           regfile_we_ex, regfile_we_wb, regfile_alu_we_fw,
                           ex_is_a, ex_is_b, ex_is_c, wb_is_a, alu_is_a);
      cmp_bit("hazard load_stall", exp_haz[2], load_stall);
      cmp_bit("hazard jr_stall", exp_haz[1], jr_stall);
      cmp_bit("hazard deassert_we", exp_haz[0], deassert_we);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and directed checks
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : stimulus
    logic [31:0] r;
    int unsigned pulses;
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    instr_valid  = 1'b0;
    clear_inputs();

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    // idle outputs straight after reset
    @(negedge clk);
    cmp_bit("reset core_busy", 1'b0, core_busy);
    cmp_bit("reset instr_req", 1'b0, instr_req);
    cmp_bit("reset pc_set", 1'b0, pc_set);
    cmp_bit("reset exc_ack", 1'b0, exc_ack);
    cmp_bit("reset halt_if", 1'b0, halt_if);
    cmp_bit("reset halt_id", 1'b0, halt_id);
    cmp_bit("reset is_decoding", 1'b0, is_decoding);

    @(posedge clk);
    fetch_enable <= 1'b1;
    @(negedge clk);
    cmp_bit("boot pc_set before state change", 1'b0, pc_set);
    // BOOT_SET one clock later
    @(posedge clk);
    @(negedge clk);
    cmp_bit("boot pc_set", 1'b1, pc_set);
    cmp_pc("boot pc_mux", ctrl_pkg::PC_BOOT, pc_mux);
    cmp_bit("boot core_busy", 1'b1, core_busy);
    @(posedge clk);
    id_valid    <= 1'b1;
    instr_valid <= 1'b1;
    @(negedge clk);
    cmp_bit("boot pulse single cycle", 1'b0, pc_set);
    @(posedge clk);
    id_valid <= 1'b0;
    @(negedge clk);
    cmp_bit("decode entered", 1'b1, is_decoding);

    // random hazard and forwarding traffic in DECODE
    repeat (RANDOM_CYCLES)
    begin
      @(posedge clk);
      draw_bits(16, r);
      jump_in_dec       <= pipe_pkg::jump_kind_e'(r[1:0]);
      illegal_insn      <= r[2];
      data_req_ex       <= r[3];
      regfile_we_ex     <= r[4];
      regfile_we_wb     <= r[5];
      regfile_alu_we_fw <= r[6];
      {ex_is_a, ex_is_b, ex_is_c}    <= r[9:7];
      {wb_is_a, wb_is_b, wb_is_c}    <= r[12:10];
      {alu_is_a, alu_is_b, alu_is_c} <= r[15:13];
      @(negedge clk);
      cmp_bit("random is_decoding", 1'b1, is_decoding);
    end

    // random jumps may leave the done flag set, one id_valid clears it
    @(posedge clk);
    clear_inputs();
    id_valid <= 1'b1;
    @(posedge clk);
    id_valid <= 1'b0;

    // jal without stall
    @(posedge clk);
    jump_in_dec <= pipe_pkg::JUMP_JAL;
    @(negedge clk);
    cmp_pc("jal pc_mux", ctrl_pkg::PC_JUMP, pc_mux);
    cmp_bit("jal pc_set", 1'b1, pc_set);
    cmp_bit("jal exc_ack", 1'b0, exc_ack);
    @(posedge clk);
    jump_in_dec <= pipe_pkg::JUMP_NONE;
    id_valid    <= 1'b1;

    // exception entry, request dropped after the ack
    @(posedge clk);
    id_valid <= 1'b0;
    exc_req  <= 1'b1;
    @(negedge clk);
    cmp_pc("exception pc_mux", ctrl_pkg::PC_EXCEPTION, pc_mux);
    cmp_bit("exception pc_set", 1'b1, pc_set);
    cmp_bit("exception exc_ack", 1'b1, exc_ack);
    cmp_bit("exception halt_id", 1'b1, halt_id);
    cmp_bit("exception save_pc_id", 1'b1, save_pc_id);

    // eret while fetch stays enabled, no flush
    @(posedge clk);
    exc_req   <= 1'b0;
    eret_insn <= 1'b1;
    @(negedge clk);
    cmp_pc("eret pc_mux", ctrl_pkg::PC_ERET, pc_mux);
    cmp_bit("eret pc_set", 1'b1, pc_set);
    cmp_bit("eret exc_ack", 1'b0, exc_ack);
    cmp_bit("eret halt_if", 1'b0, halt_if);

    // taken branch beats a jal in ID
    @(posedge clk);
    eret_insn       <= 1'b0;
    branch_taken_ex <= 1'b1;
    jump_in_dec     <= pipe_pkg::JUMP_JAL;
    @(negedge clk);
    cmp_pc("branch pc_mux", ctrl_pkg::PC_BRANCH, pc_mux);
    cmp_bit("branch pc_set", 1'b1, pc_set);
    cmp_bit("branch is_decoding", 1'b0, is_decoding);
    cmp_bit("branch exc_ack", 1'b0, exc_ack);

    ////////////////////////////////////////////////////////////////////////////
    // jalr held behind a pending write of its base
    ////////////////////////////////////////////////////////////////////////////

    @(posedge clk);
    branch_taken_ex <= 1'b0;
    jump_in_dec     <= pipe_pkg::JUMP_JALR;
    regfile_we_wb   <= 1'b1;
    wb_is_a         <= 1'b1;
    repeat (3)
    begin
      @(negedge clk);
      cmp_bit("jalr stalled jr_stall", 1'b1, jr_stall);
      cmp_bit("jalr stalled pc_set", 1'b0, pc_set);
      @(posedge clk);
    end
    regfile_we_wb <= 1'b0;
    wb_is_a       <= 1'b0;
    pulses = 0;
    repeat (4)
    begin
      @(negedge clk);
      cmp_pc("jalr pc_mux", ctrl_pkg::PC_JUMP, pc_mux);
      if (pc_set)
        pulses++;
      @(posedge clk);
    end
    id_valid <= 1'b1;
    @(negedge clk);
    cmp_bit("jalr no reissue at id_valid", 1'b0, pc_set);
    check_count++;
    if (pulses != 1)
    begin
      err_count++;
      $display("CHECK FAILED jalr pc_set pulses before id_valid: expected 1, actual %0d",
               pulses);
    end
    @(posedge clk);
    jump_in_dec <= pipe_pkg::JUMP_NONE;
    id_valid    <= 1'b0;

    ////////////////////////////////////////////////////////////////////////////
    // flush into sleep, then wake on an exception
    ////////////////////////////////////////////////////////////////////////////

    @(posedge clk);
    pipe_flush   <= 1'b1;
    fetch_enable <= 1'b0;
    @(negedge clk);
    cmp_bit("flush halt_if", 1'b1, halt_if);
    cmp_bit("flush halt_id", 1'b1, halt_id);
    @(posedge clk);
    pipe_flush <= 1'b0;
    @(negedge clk);
    cmp_bit("flush ex halt_if", 1'b1, halt_if);
    cmp_bit("flush ex core_busy", 1'b1, core_busy);
    @(posedge clk);
    ex_valid <= 1'b1;
    @(posedge clk);
    ex_valid <= 1'b0;
    wb_valid <= 1'b1;
    @(negedge clk);
    cmp_bit("flush wb core_busy", 1'b1, core_busy);
    @(posedge clk);
    wb_valid <= 1'b0;
    @(negedge clk);
    cmp_bit("sleep core_busy", 1'b0, core_busy);
    cmp_bit("sleep instr_req", 1'b0, instr_req);
    @(posedge clk);
    exc_req <= 1'b1;
    @(negedge clk);
    // wake only takes effect on the next edge
    cmp_bit("sleep core_busy with request", 1'b0, core_busy);
    @(posedge clk);
    @(negedge clk);
    cmp_bit("wake core_busy", 1'b1, core_busy);
    cmp_bit("wake exc_ack", 1'b1, exc_ack);
    cmp_pc("wake pc_mux", ctrl_pkg::PC_EXCEPTION, pc_mux);
    @(posedge clk);
    exc_req <= 1'b0;
    @(negedge clk);
    cmp_bit("wake exc_ack dropped", 1'b0, exc_ack);

    $display("checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // stops a run whose stimulus never completes
  initial
  begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout: stimulus did not complete within %0d ns", TIMEOUT_NS);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: all.f
+incdir+hw
+incdir+verif
hw/ctrl_pkg.sv
hw/pipe_pkg.sv
hw/ctrl_fsm.sv
hw/hazard_unit.sv
hw/fwd_unit.sv
hw/ctrl_top.sv
verif/tb_ctrl.sv

// File: Bender.yml
package:
  name: ctrl_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/ctrl_pkg.sv
      - hw/pipe_pkg.sv
      - hw/ctrl_fsm.sv
      - hw/hazard_unit.sv
      - hw/fwd_unit.sv
      - hw/ctrl_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_ctrl.sv
